// File: Makefile
TOOL    = verilator
FLAGS   = --binary --timing --assert -Wno-fatal
TOP     = orbTop_tb
FLIST   = orbTop.f
OBJDIR  = obj_dir
LOG     = sim.log
RUNOPTS = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) $(RUNOPTS) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: common/framePkg.sv
`default_nettype none

package framePkg;

	typedef logic [11:0] orbWord_t;  // one frame word
	typedef logic [4:0] frameAddr_t; // word slot within a frame
	typedef logic [2:0] seqTag_t;    // slow word sequence tag

	// frame layout, fast region first
	localparam int FRAME_WORDS = 32;
	localparam int FAST_WORDS = 24;
	localparam int SLOW_BASE = 24;
	localparam int SLOW_WORDS = FRAME_WORDS - SLOW_BASE;

endpackage

`default_nettype wire

// File: common/serialPkg.sv
`default_nettype none

package serialPkg;

	typedef logic [7:0] byte_t;   // one received data byte
	typedef logic [2:0] bitIdx_t; // data bit position within a byte

	// 8N1 receiver phases
	typedef enum logic [1:0] {
		rxIdle,
		rxStart,
		rxData,
		rxStop
	} rxState_t;

endpackage

`default_nettype wire

// File: design/frameBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module frameBuffer (
	input wire logic clk100MHz,
	input wire logic rstN,
	input wire framePkg::orbWord_t fastWord,
	input wire framePkg::frameAddr_t fastAddr,
	input wire logic fastValid,
	input wire framePkg::orbWord_t slowWord,
	input wire framePkg::frameAddr_t slowAddr,
	input wire logic slowValid,
	input wire framePkg::frameAddr_t rdAddr,
	input wire logic rdEn,
	input wire logic frameEnd,
	output framePkg::orbWord_t rdWord,
	output logic frameStart
);

	localparam int DEPTH = framePkg::FRAME_WORDS;

	framePkg::orbWord_t mem [2][DEPTH];
	logic [DEPTH-1:0] live [2]; // slot written since it was last sent
	logic fillSel;
	logic sendSel;

	framePkg::orbWord_t pendWord;
	framePkg::frameAddr_t pendAddr;
	logic pendValid;
	logic pendLoad;

	framePkg::orbWord_t wrWord;
	framePkg::frameAddr_t wrAddr;
	logic wrEn;

	assign sendSel = ~fillSel;
	assign pendLoad = slowValid && (fastValid || pendValid); // slow word loses this cycle

	// fast first, then a parked slow word, then a fresh slow word
	always_comb begin
		wrEn = fastValid | pendValid | slowValid;
		wrWord = slowWord;
		wrAddr = slowAddr;
		if (fastValid) begin
			wrWord = fastWord;
			wrAddr = fastAddr;
		end else if (pendValid) begin
			wrWord = pendWord;
			wrAddr = pendAddr;
		end
	end

	always_ff @(posedge clk100MHz) begin
		if (!rstN) begin
			pendValid <= 1'b0;
		end else if (pendLoad) begin
			pendValid <= 1'b1;
		end else if (!fastValid) begin
			pendValid <= 1'b0; // parked word went out
		end
	end

	always_ff @(posedge clk100MHz) begin
		if (pendLoad) begin
			pendWord <= slowWord;
			pendAddr <= slowAddr;
		end
	end

	always_ff @(posedge clk100MHz) begin
		if (!rstN) begin
			fillSel <= 1'b0;
			frameStart <= 1'b0;
		end else begin
			frameStart <= frameEnd;
			if (frameEnd) begin
				fillSel <= ~fillSel; // ping-pong swap
			end
		end
	end

	always_ff @(posedge clk100MHz) begin
		if (wrEn) begin
			mem[fillSel][wrAddr] <= wrWord;
		end
	end

	always_ff @(posedge clk100MHz) begin
		if (!rstN) begin
			live[0] <= '0;
			live[1] <= '0;
			rdWord <= '0;
		end else begin
			if (wrEn) begin
				live[fillSel][wrAddr] <= 1'b1;
			end
			if (rdEn) begin
				live[sendSel][rdAddr] <= 1'b0; // clear after read
				rdWord <= live[sendSel][rdAddr] ? mem[sendSel][rdAddr] : '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/frameReader.sv
`timescale 1ns/1ps
`default_nettype none

module frameReader #(
	parameter int WORD_DIV = 16
) (
	input wire logic clk100MHz,
	input wire logic rstN,
	input wire framePkg::orbWord_t rdWord,
	output framePkg::frameAddr_t rdAddr,
	output logic rdEn,
	output logic frameEnd,
	output framePkg::orbWord_t orbWord,
	output logic orbWordValid,
	output logic orbFrame
);

	localparam int DIV_W = $clog2(WORD_DIV);
	localparam logic [DIV_W-1:0] DIV_END = DIV_W'(WORD_DIV - 1);
	localparam framePkg::frameAddr_t LAST_ADDR =
		framePkg::frameAddr_t'(framePkg::FRAME_WORDS - 1);

	logic [DIV_W-1:0] divCnt;

	always_ff @(posedge clk100MHz) begin
		if (!rstN) begin
			divCnt <= '0;
			rdEn <= 1'b0;
		end else begin
			rdEn <= (divCnt == DIV_END); // one read per word period
			divCnt <= (divCnt == DIV_END) ? '0 : divCnt + 1'b1;
		end
	end

	always_ff @(posedge clk100MHz) begin
		if (!rstN) begin
			rdAddr <= '0;
			frameEnd <= 1'b0;
			orbWordValid <= 1'b0;
			orbFrame <= 1'b0;
		end else begin
			orbWordValid <= rdEn;
			orbFrame <= rdEn && (rdAddr == '0); // frame marker on slot 0
			frameEnd <= rdEn && (rdAddr == LAST_ADDR);
			if (rdEn) begin
				rdAddr <= (rdAddr == LAST_ADDR) ? '0 : rdAddr + 1'b1;
			end
		end
	end

	// buffer word lands in the same cycle as the valid stage
	assign orbWord = rdWord;

endmodule

`default_nettype wire

// File: design/orbTop.sv
`timescale 1ns/1ps
`default_nettype none

module orbTop #(
	parameter int BIT_DIV = 8,
	parameter int WORD_DIV = 16
) (
	input wire logic clk100MHz,
	input wire logic rstN,
	input wire logic rxFast,
	input wire logic rxSlow,
	output wire framePkg::orbWord_t orbWord,
	output wire logic orbWordValid,
	output wire logic orbFrame
);

	wire serialPkg::byte_t fastByte;
	wire serialPkg::byte_t slowByte;
	wire logic fastByteValid;
	wire logic slowByteValid;
	wire framePkg::orbWord_t fastWord;
	wire framePkg::orbWord_t slowWord;
	wire framePkg::frameAddr_t fastAddr;
	wire framePkg::frameAddr_t slowAddr;
	wire logic fastValid;
	wire logic slowValid;
	wire framePkg::frameAddr_t rdAddr;
	wire framePkg::orbWord_t rdWord;
	wire logic rdEn;
	wire logic frameEnd;
	wire logic frameStart;

	uartRx #(.BIT_DIV(BIT_DIV)) instRxFast (
		.clk100MHz(clk100MHz),
		.rstN(rstN),
		.rx(rxFast),
		.byteData(fastByte),
		.byteValid(fastByteValid)
	);

	uartRx #(.BIT_DIV(BIT_DIV)) instRxSlow (
		.clk100MHz(clk100MHz),
		.rstN(rstN),
		.rx(rxSlow),
		.byteData(slowByte),
		.byteValid(slowByteValid)
	);

	fastPacker instFastPack (
		.clk100MHz(clk100MHz),
		.rstN(rstN),
		.byteData(fastByte),
		.byteValid(fastByteValid),
		.frameStart(frameStart),
		.wordData(fastWord),
		.wordAddr(fastAddr),
		.wordValid(fastValid)
	);

	slowPacker instSlowPack (
		.clk100MHz(clk100MHz),
		.rstN(rstN),
		.byteData(slowByte),
		.byteValid(slowByteValid),
		.frameStart(frameStart),
		.wordData(slowWord),
		.wordAddr(slowAddr),
		.wordValid(slowValid)
	);

	frameBuffer instBuf (
		.clk100MHz(clk100MHz),
		.rstN(rstN),
		.fastWord(fastWord),
		.fastAddr(fastAddr),
		.fastValid(fastValid),
		.slowWord(slowWord),
		.slowAddr(slowAddr),
		.slowValid(slowValid),
		.rdAddr(rdAddr),
		.rdEn(rdEn),
		.frameEnd(frameEnd),
		.rdWord(rdWord),
		.frameStart(frameStart)
	);

	frameReader #(.WORD_DIV(WORD_DIV)) instReader (
		.clk100MHz(clk100MHz),
		.rstN(rstN),
		.rdWord(rdWord),
		.rdAddr(rdAddr),
		.rdEn(rdEn),
		.frameEnd(frameEnd),
		.orbWord(orbWord),
		.orbWordValid(orbWordValid),
		.orbFrame(orbFrame)
	);

endmodule

`default_nettype wire

// File: design/uartRx.sv
`timescale 1ns/1ps
`default_nettype none

module uartRx #(
	parameter int BIT_DIV = 8
) (
	input wire logic clk100MHz,
	input wire logic rstN,
	input wire logic rx,
	output serialPkg::byte_t byteData,
	output logic byteValid
);

	localparam int CNT_W = $clog2(BIT_DIV) + 1;
	localparam logic [CNT_W-1:0] MID_CNT = CNT_W'(BIT_DIV / 2 - 1);
	localparam logic [CNT_W-1:0] END_CNT = CNT_W'(BIT_DIV - 1);

	logic rxMeta;
	logic rxSync;
	logic rxPrev;
	serialPkg::rxState_t state;
	logic [CNT_W-1:0] cnt;
	serialPkg::bitIdx_t bitIdx;
	serialPkg::byte_t shiftReg;

	always_ff @(posedge clk100MHz) begin
		if (!rstN) begin
			rxMeta <= 1'b1; // line idles high
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
		end else begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxPrev <= rxSync;
		end
	end

	always_ff @(posedge clk100MHz) begin
		if (!rstN) begin
			state <= serialPkg::rxIdle;
			cnt <= '0;
			bitIdx <= '0;
			byteValid <= 1'b0;
		end else begin
			byteValid <= 1'b0;
			case (state)
				serialPkg::rxIdle: begin
					cnt <= '0;
					if (rxPrev && !rxSync) begin
						state <= serialPkg::rxStart; // falling edge of start bit
					end
				end
				serialPkg::rxStart: begin
					if (cnt == MID_CNT) begin
						cnt <= '0;
						bitIdx <= '0;
						// glitch shorter than half a bit goes back to idle
						state <= rxSync ? serialPkg::rxIdle : serialPkg::rxData;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				serialPkg::rxData: begin
					if (cnt == END_CNT) begin
						cnt <= '0;
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7) begin
							state <= serialPkg::rxStop;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				serialPkg::rxStop: begin
					if (cnt == END_CNT) begin
						state <= serialPkg::rxIdle;
						byteValid <= rxSync; // framing error drops the byte
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= serialPkg::rxIdle;
			endcase
		end
	end

	always_ff @(posedge clk100MHz) begin
		if (state == serialPkg::rxData && cnt == END_CNT) begin
			shiftReg <= {rxSync, shiftReg[7:1]}; // lsb first
		end
		if (state == serialPkg::rxStop && cnt == END_CNT) begin
			byteData <= shiftReg;
		end
	end

endmodule

`default_nettype wire

// File: orbTop.f
common/serialPkg.sv
common/framePkg.sv
design/uartRx.sv
packer/fastPacker.sv
packer/slowPacker.sv
design/frameBuffer.sv
design/frameReader.sv
design/orbTop.sv
tb/orbTop_sva.sv
tb/orbTop_tb.sv

// File: packer/fastPacker.sv
`timescale 1ns/1ps
`default_nettype none

module fastPacker (
	input wire logic clk100MHz,
	input wire logic rstN,
	input wire serialPkg::byte_t byteData,
	input wire logic byteValid,
	input wire logic frameStart,
	output framePkg::orbWord_t wordData,
	output framePkg::frameAddr_t wordAddr,
	output logic wordValid
);

	localparam framePkg::frameAddr_t FAST_END = framePkg::frameAddr_t'(framePkg::FAST_WORDS);

	logic [1:0] phase;
	logic [1:0] phaseNow;
	framePkg::frameAddr_t addrCnt;
	framePkg::frameAddr_t addrNow;
	serialPkg::byte_t byteA;
	serialPkg::byte_t byteB;
	logic roomLeft;

	// a new frame restarts the triple and the region
	assign phaseNow = frameStart ? 2'd0 : phase;
	assign addrNow = frameStart ? '0 : addrCnt;
	assign roomLeft = (addrNow != FAST_END);

	always_ff @(posedge clk100MHz) begin
		if (!rstN) begin
			phase <= 2'd0;
			addrCnt <= '0;
			wordValid <= 1'b0;
		end else begin
			wordValid <= 1'b0;
			phase <= phaseNow;
			addrCnt <= addrNow;
			if (byteValid) begin
				case (phaseNow)
					2'd0: phase <= 2'd1;
					2'd1: begin
						phase <= 2'd2;
						wordValid <= roomLeft;
						if (roomLeft) begin
							addrCnt <= addrNow + 1'b1;
						end
					end
					default: begin
						phase <= 2'd0; // triple complete
						wordValid <= roomLeft;
						if (roomLeft) begin
							addrCnt <= addrNow + 1'b1;
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk100MHz) begin
		if (byteValid) begin
			wordAddr <= addrNow;
			case (phaseNow)
				2'd0: byteA <= byteData;
				2'd1: begin
					byteB <= byteData;
					wordData <= {byteA, byteData[7:4]}; // a plus upper nibble of b
				end
				default: wordData <= {byteB[3:0], byteData}; // lower nibble of b plus c
			endcase
		end
	end

endmodule

`default_nettype wire

// File: packer/slowPacker.sv
`timescale 1ns/1ps
`default_nettype none

module slowPacker (
	input wire logic clk100MHz,
	input wire logic rstN,
	input wire serialPkg::byte_t byteData,
	input wire logic byteValid,
	input wire logic frameStart,
	output framePkg::orbWord_t wordData,
	output framePkg::frameAddr_t wordAddr,
	output logic wordValid
);

	localparam logic [3:0] SLOT_END = 4'(framePkg::SLOW_WORDS);
	localparam framePkg::frameAddr_t SLOW_START = framePkg::frameAddr_t'(framePkg::SLOW_BASE);

	framePkg::seqTag_t seq;
	logic [3:0] slotCnt;
	logic [3:0] slotNow;
	logic roomLeft;
	logic parityBit;

	assign slotNow = frameStart ? '0 : slotCnt;
	assign roomLeft = (slotNow != SLOT_END);
	assign parityBit = ~^byteData; // odd count of ones over byte and parity

	always_ff @(posedge clk100MHz) begin
		if (!rstN) begin
			seq <= '0;
			slotCnt <= '0;
			wordValid <= 1'b0;
		end else begin
			wordValid <= 1'b0;
			slotCnt <= slotNow;
			if (byteValid) begin
				seq <= seq + 1'b1; // counts every byte, dropped ones too
				wordValid <= roomLeft;
				if (roomLeft) begin
					slotCnt <= slotNow + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk100MHz) begin
		if (byteValid) begin
			wordData <= {seq, parityBit, byteData};
			wordAddr <= SLOW_START + framePkg::frameAddr_t'(slotNow);
		end
	end

endmodule

`default_nettype wire

// File: tb/orbTop_sva.sv
`timescale 1ns/1ps
`default_nettype none

module orbTop_sva #(
	parameter int WORD_DIV = 16
) (
	input wire logic clk100MHz,
	input wire logic rstN,
	input wire framePkg::orbWord_t orbWord,
	input wire logic orbWordValid,
	input wire logic orbFrame,
	input wire framePkg::frameAddr_t rdAddr
);

	localparam framePkg::frameAddr_t SLOW_START = framePkg::frameAddr_t'(framePkg::SLOW_BASE);

	int failCount = 0;
	int sinceValid;
	logic validSeen;

	always_ff @(posedge clk100MHz) begin
		if (!rstN) begin
			sinceValid <= 0;
			validSeen <= 1'b0;
		end else if (orbWordValid) begin
			sinceValid <= 1; // cycles since the last output word
			validSeen <= 1'b1;
		end else begin
			sinceValid <= sinceValid + 1;
		end
	end

	frameWithValid: assert property (@(posedge clk100MHz) disable iff (!rstN)
		orbFrame |-> orbWordValid)
	else begin
		failCount++;
		$error("orbFrame high without orbWordValid");
	end

	wordPeriod: assert property (@(posedge clk100MHz) disable iff (!rstN)
		orbWordValid && validSeen |-> sinceValid == WORD_DIV)
	else begin
		failCount++;
		$error("orbWordValid came %0d cycles after the previous word", sinceValid);
	end

	noWordGap: assert property (@(posedge clk100MHz) disable iff (!rstN)
		validSeen |-> sinceValid <= WORD_DIV)
	else begin
		failCount++;
		$error("orbWordValid missing for %0d cycles", sinceValid);
	end

	quietInReset: assert property (@(posedge clk100MHz)
		!rstN && !$past(rstN) |-> !orbWordValid && !orbFrame)
	else begin
		failCount++;
		$error("output strobes high during reset");
	end

	// word on the output belongs to the address read one cycle earlier
	slowParity: assert property (@(posedge clk100MHz) disable iff (!rstN)
		orbWordValid && $past(rdAddr) >= SLOW_START && orbWord != '0 |-> ^orbWord[8:0])
	else begin
		failCount++;
		$error("slow word %h has even parity", orbWord);
	end

endmodule

bind orbTop orbTop_sva #(.WORD_DIV(WORD_DIV)) svaInst (
	.clk100MHz(clk100MHz),
	.rstN(rstN),
	.orbWord(orbWord),
	.orbWordValid(orbWordValid),
	.orbFrame(orbFrame),
	.rdAddr(rdAddr)
);

`default_nettype wire

// File: tb/orbTop_tb.sv
`timescale 1ns/1ps
`default_nettype none

module orbTop_tb;

	localparam int BIT_DIV = 8;
	localparam int WORD_DIV = 128; // long frames, 39 fast bytes fit in one
	localparam int FRAME_CYCLES = WORD_DIV * framePkg::FRAME_WORDS;
	localparam int NUM_FRAMES = 13; // frames walked through by all tests

	logic clk100MHz;
	logic rstN;
	logic rxFast;
	logic rxSlow;
	wire framePkg::orbWord_t orbWord;
	wire logic orbWordValid;
	wire logic orbFrame;

	logic [31:0] lfsr;
	framePkg::orbWord_t expFrame [framePkg::FRAME_WORDS];
	serialPkg::byte_t fastQ [$];
	serialPkg::byte_t slowQ [$];
	serialPkg::byte_t heldA;
	serialPkg::byte_t heldB;
	int fastPhase;
	int fastSlot;
	int slowSlot;
	logic [2:0] expSeq; // slow tag, survives frame swaps
	int testErrs;
	int errCount;
	int testsRun;
	int testsFailed;

	orbTop #(.BIT_DIV(BIT_DIV), .WORD_DIV(WORD_DIV)) u_dut (
		.clk100MHz(clk100MHz),
		.rstN(rstN),
		.rxFast(rxFast),
		.rxSlow(rxSlow),
		.orbWord(orbWord),
		.orbWordValid(orbWordValid),
		.orbFrame(orbFrame)
	);

	initial begin
		clk100MHz = 1'b0;
		forever #5 clk100MHz = ~clk100MHz;
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	task automatic drawBytes(input logic toFast, input int count);
		serialPkg::byte_t value;
		for (int i = 0; i < count; i++) begin
			for (int b = 0; b < 8; b++) begin
				value = {lfsrBit(), value[7:1]};
			end
			if (toFast) begin
				fastQ.push_back(value);
			end else begin
				slowQ.push_back(value);
			end
		end
	endtask

	task automatic putFast(input framePkg::orbWord_t word);
		if (fastSlot < framePkg::FAST_WORDS) begin
			expFrame[fastSlot] = word;
		end
		fastSlot++; // words past the region are lost
	endtask

	task automatic modelFast(input serialPkg::byte_t value);
		case (fastPhase)
			0: heldA = value;
			1: begin
				heldB = value;
				putFast({heldA, value[7:4]});
			end
			default: putFast({heldB[3:0], value});
		endcase
		fastPhase = (fastPhase + 1) % 3;
	endtask

	task automatic modelSlow(input serialPkg::byte_t value);
		int ones;
		logic parity;
		ones = 0;
		for (int b = 0; b < 8; b++) begin
			ones += int'(value[b]);
		end
		parity = (ones % 2 == 0); // nine bits end up with an odd count
		if (slowSlot < framePkg::SLOW_WORDS) begin
			expFrame[framePkg::SLOW_BASE + slowSlot] = {expSeq, parity, value};
		end
		slowSlot++;
		expSeq++;
	endtask

	// start, data lsb first, stop, then one idle bit
	task automatic sendByte(input logic toFast, input serialPkg::byte_t value, input logic stopBit);
		logic [10:0] bits;
		bits = {1'b1, stopBit, value, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(posedge clk100MHz);
			#1;
			if (toFast) begin
				rxFast = bits[i];
			end else begin
				rxSlow = bits[i];
			end
			repeat (BIT_DIV - 1) @(posedge clk100MHz);
		end
	endtask

	task automatic sendBurst(input logic toFast, input int badIdx);
		serialPkg::byte_t value;
		int idx;
		idx = 0;
		while ((toFast ? fastQ.size() : slowQ.size()) > 0) begin
			if (toFast) begin
				value = fastQ.pop_front();
			end else begin
				value = slowQ.pop_front();
			end
			sendByte(toFast, value, idx != badIdx);
			if (idx != badIdx && toFast) begin
				modelFast(value);
			end else if (idx != badIdx) begin
				modelSlow(value);
			end
			idx++;
		end
	endtask

	task automatic waitFrameStart();
		do begin
			@(negedge clk100MHz);
		end while (!(orbWordValid && orbFrame));
	endtask

	task automatic clearModel();
		foreach (expFrame[i]) begin
			expFrame[i] = '0;
		end
		fastPhase = 0;
		fastSlot = 0;
		slowSlot = 0;
		testErrs = 0;
	endtask

	task automatic checkIdle();
		assert (!orbWordValid && !orbFrame) else begin
			$display("Error at %0t ns: orbWordValid/orbFrame are %b/%b, expected 0/0",
				$time, orbWordValid, orbFrame);
			testErrs++;
		end
	endtask

	task automatic reportTest(input string name);
		testsRun++;
		errCount += testErrs;
		if (testErrs == 0) begin
			$display("test %0d, %s: ok", testsRun, name);
		end else begin
			testsFailed++;
			$display("test %0d, %s: %0d mismatches", testsRun, name, testErrs);
		end
	endtask

	// whole next frame against the model, word 0 carries the marker
	task automatic checkFrame(input string name);
		waitFrameStart();
		for (int i = 0; i < framePkg::FRAME_WORDS; i++) begin
			if (i > 0) begin
				do begin
					@(negedge clk100MHz);
				end while (!orbWordValid);
			end
			assert (orbWord == expFrame[i]) else begin
				$display("Error at %0t ns: orbWord word %0d is %h, expected %h",
					$time, i, orbWord, expFrame[i]);
				testErrs++;
			end
			assert (orbFrame == (i == 0)) else begin
				$display("Error at %0t ns: orbFrame word %0d is %b, expected %b",
					$time, i, orbFrame, i == 0);
				testErrs++;
			end
		end
		reportTest(name);
	endtask

	task automatic runTest(input string name, input int nFast, input int nSlow,
		input int badFast, input int badSlow);
		waitFrameStart();
		clearModel();
		drawBytes(1'b1, nFast);
		drawBytes(1'b0, nSlow);
		fork
			sendBurst(1'b1, badFast);
			sendBurst(1'b0, badSlow);
		join
		checkFrame(name);
	endtask

	initial begin
		rstN = 1'b0;
		rxFast = 1'b1;
		rxSlow = 1'b1;
		lfsr = 32'h28cf_6f75;
		expSeq = '0;
		errCount = 0;
		testsRun = 0;
		testsFailed = 0;
		clearModel();
		repeat (3) @(posedge clk100MHz);
		@(negedge clk100MHz);
		checkIdle();
		@(posedge clk100MHz);
		#1;
		rstN = 1'b1;
		@(negedge clk100MHz);
		checkIdle();
		checkFrame("reset and empty first frame");
		runTest("six fast bytes", 6, 0, -1, -1);
		runTest("slow bytes, first frame", 0, 3, -1, -1);
		runTest("slow bytes, next frame", 0, 3, -1, -1);
		runTest("fast and slow together", 6, 6, -1, -1);
		runTest("both regions overfull", 39, 10, -1, -1);
		runTest("low stop bit dropped", 4, 2, 1, 0);
		$display("tests run %0d, failed %0d, word errors %0d, assertion failures %0d",
			testsRun, testsFailed, errCount, u_dut.svaInst.failCount);
		if (testsFailed == 0 && u_dut.svaInst.failCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		repeat ((NUM_FRAMES + 2) * FRAME_CYCLES) @(posedge clk100MHz);
		$display("Watchdog expired at %0t ns, the frame sequence did not complete", $time);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
